/* design/dcache_cfg.svh */
// cache geometry defines for ways, sets, words per line and address width
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// associativity
`define DC_WAYS 2

// sets per way
`define DC_SETS 64

// 32-bit words in one cache line
`define DC_LINE_WORDS 4

// byte address width on both CPU and memory side
`define DC_ADDR_W 32

`endif

/* design/dcache_pkg.sv */
// cache-side types for address fields, tag entry, CPU request, store buffer and miss states
`include "dcache_cfg.svh"

package dcache_pkg;

    localparam int unsigned INDEX_W  = $clog2(`DC_SETS);
    localparam int unsigned OFFSET_W = $clog2(`DC_LINE_WORDS * 4);
    localparam int unsigned TAG_W    = `DC_ADDR_W - INDEX_W - OFFSET_W;
    localparam int unsigned WORD_W   = $clog2(`DC_LINE_WORDS);
    localparam int unsigned WAY_W    = $clog2(`DC_WAYS);

    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;   // byte offset in a line
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [WAY_W-1:0]    way_t;
    typedef logic [WORD_W-1:0]   word_t;     // word within a line

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef struct packed {
        logic        op;      // 1 for store
        tag_t        tag;
        index_t      index;
        offset_t     offset;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    // merged store word waiting for the data array
    typedef struct packed {
        logic        valid;
        way_t        way;
        index_t      index;
        word_t       word;
        logic [31:0] data;
    } store_buf_t;

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } miss_state_t;

endpackage

/* design/mem_bus_pkg.sv */
// line-wide memory bus types for line data, request and response
`include "dcache_cfg.svh"

package mem_bus_pkg;

    typedef logic [`DC_LINE_WORDS*32-1:0] line_t;
    typedef logic [`DC_ADDR_W-1:0]        mem_addr_t;

    // levels held until the matching rdy
    typedef struct packed {
        logic      rd_req;
        mem_addr_t rd_addr;   // line aligned
        logic      wr_req;
        mem_addr_t wr_addr;   // line aligned
        line_t     wr_line;
    } mem_req_t;

    typedef struct packed {
        logic  rd_rdy;
        logic  ret_valid;     // one-cycle pulse with ret_line
        line_t ret_line;
        logic  wr_rdy;
        logic  wr_done;       // one-cycle pulse
    } mem_rsp_t;

endpackage

/* design/way_ram.sv */
// per-set storage of one payload per way, with registered read and single write port
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module way_ram #(
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_en,
    input  dcache_pkg::index_t rd_addr,
    input  logic               we,
    input  dcache_pkg::index_t wr_addr,
    input  payload_t           din,
    output payload_t           dout
);

    payload_t mem [`DC_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                mem[s] <= '0;   // all entries invalid and clean
            end
            dout <= '0;
        end else begin
            if (we) begin
                mem[wr_addr] <= din;
            end
            if (rd_en) begin
                // write to the same set on this edge is seen at once
                dout <= (we && wr_addr == rd_addr) ? din : mem[rd_addr];
            end
        end
    end

endmodule

/* design/line_ram.sv */
// data lines of one way with per-word write enables and registered read
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module line_ram (
    input  logic                      clk,
    input  logic                      rd_en,
    input  dcache_pkg::index_t        rd_addr,
    input  logic [`DC_LINE_WORDS-1:0] word_we,
    input  dcache_pkg::index_t        wr_addr,
    input  mem_bus_pkg::line_t        din,
    output mem_bus_pkg::line_t        dout
);

    logic [31:0] mem [`DC_SETS][`DC_LINE_WORDS];

    // refill sets all enables, a store one
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_LINE_WORDS; w++) begin
            if (word_we[w]) begin
                mem[wr_addr][w] <= din[32*w +: 32];
            end
        end
    end

    // store buffer drain on the read edge is forwarded word by word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                if (word_we[w] && wr_addr == rd_addr) begin
                    dout[32*w +: 32] <= din[32*w +: 32];
                end else begin
                    dout[32*w +: 32] <= mem[rd_addr][w];
                end
            end
        end
    end

endmodule

/* design/lru_table.sv */
// least-recently-used bit per set with victim lookup and update on touch
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module lru_table (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::index_t index,
    input  logic               touch,
    input  dcache_pkg::way_t   touch_way,
    output dcache_pkg::way_t   victim
);

    import dcache_pkg::*;

    way_t lru_q [`DC_SETS];   // names the least recently used way

    assign victim = lru_q[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                lru_q[s] <= '0;
            end
        end else if (touch) begin
            lru_q[index] <= ~touch_way;   // two ways so the other one ages
        end
    end

endmodule

/* design/miss_fsm.sv */
// miss handling FSM through lookup, writeback, refill and refill done
`timescale 1ns/10ps

module miss_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lookup_miss,
    input  logic                    victim_dirty,
    input  mem_bus_pkg::mem_rsp_t   mem_rsp,
    output dcache_pkg::miss_state_t state
);

    import dcache_pkg::*;

    miss_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (lookup_miss) begin
                    // dirty victim goes out before the refill
                    if (victim_dirty) begin
                        state_next = MISS_DIRTY;
                    end else begin
                        state_next = MISS_CLEAN;
                    end
                end
            end
            MISS_DIRTY: begin
                if (mem_rsp.wr_rdy) begin
                    state_next = WRITEBACK;
                end
            end
            WRITEBACK: begin
                if (mem_rsp.wr_done) begin   // line is in memory
                    state_next = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (mem_rsp.rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (mem_rsp.ret_valid) begin   // arrays written on this edge
                    state_next = REFILL_DONE;
                end
            end
            REFILL_DONE: begin
                state_next = LOOKUP;           // reread arrays then hit
            end
            default: begin
                state_next = LOOKUP;
            end
        endcase
    end

endmodule

/* design/dcache_top.sv */
// data cache top with request register, hit compare, store buffer, bypass and array muxes
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  dcache_pkg::cpu_req_t  req,
    output logic                  busy,
    output logic                  rsp_valid,
    output logic [31:0]           rdata,
    output mem_bus_pkg::mem_req_t mem_req,
    input  mem_bus_pkg::mem_rsp_t mem_rsp
);

    import dcache_pkg::*;
    import mem_bus_pkg::*;

    cpu_req_t    req_q;
    logic        req_q_valid;
    store_buf_t  store_buf;
    miss_state_t state;

    tagv_t tagv_rdata [`DC_WAYS];
    logic  dirty_rdata [`DC_WAYS];
    line_t line_rdata [`DC_WAYS];

    logic [`DC_WAYS-1:0] hit;
    logic        cache_hit;
    way_t        hit_way;
    way_t        victim;
    word_t       req_word;
    logic [31:0] hit_word;
    logic        bypass;
    logic        lookup_miss;
    logic        store_hit;
    logic        refill_we;
    logic        lru_touch;
    way_t        lru_way;
    logic        arr_rd_en;
    index_t      rd_index;
    index_t      line_wr_index;
    line_t       line_wdata;
    tagv_t       tagv_wdata;
    logic        dirty_wdata;

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] merged;
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
        end
        return merged;
    endfunction

    // accepted request, held while busy
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q_valid <= 1'b0;
        end else if (!busy) begin
            req_q_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            req_q <= req;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit[w] = tagv_rdata[w].valid && tagv_rdata[w].tag == req_q.tag;
            if (hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign cache_hit   = |hit;
    assign req_word    = req_q.offset[OFFSET_W-1:2];
    assign lookup_miss = state == LOOKUP && req_q_valid && !cache_hit;
    assign store_hit   = state == LOOKUP && req_q_valid && cache_hit && req_q.op;
    assign refill_we   = state == REFILL && mem_rsp.ret_valid;

    assign busy      = state != LOOKUP || lookup_miss;
    assign rsp_valid = state == LOOKUP && req_q_valid && cache_hit;

    // word still in the store buffer wins over the array
    assign bypass   = store_buf.valid && store_buf.way == hit_way &&
                      store_buf.index == req_q.index && store_buf.word == req_word;
    assign hit_word = bypass ? store_buf.data : line_rdata[hit_way][32*req_word +: 32];
    assign rdata    = (rsp_valid && !req_q.op) ? hit_word : '0;   // stores answer zero

    always_ff @(posedge clk) begin
        if (rst) begin
            store_buf.valid <= 1'b0;
        end else begin
            store_buf.valid <= store_hit;   // drains on the next edge
            if (store_hit) begin
                store_buf.way   <= hit_way;
                store_buf.index <= req_q.index;
                store_buf.word  <= req_word;
                store_buf.data  <= merge_bytes(hit_word, req_q.wdata, req_q.wstrb);
            end
        end
    end

    // read port holds its data during a miss so the victim stays visible
    assign arr_rd_en     = !busy || state == REFILL_DONE;
    assign rd_index      = busy ? req_q.index : req.index;
    assign line_wr_index = refill_we ? req_q.index : store_buf.index;
    assign line_wdata    = refill_we ? mem_rsp.ret_line : {`DC_LINE_WORDS{store_buf.data}};
    assign tagv_wdata    = {1'b1, req_q.tag};
    assign dirty_wdata   = !refill_we;   // refill cleans, store hit dirties

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        logic                      fill_way;
        logic [`DC_LINE_WORDS-1:0] word_we;

        assign fill_way = refill_we && victim == way_t'(w);

        always_comb begin
            word_we = '0;
            if (fill_way) begin
                word_we = '1;
            end else if (store_buf.valid && store_buf.way == way_t'(w)) begin
                word_we[store_buf.word] = 1'b1;
            end
        end

        way_ram #(.payload_t(tagv_t)) u_tagv (
            .clk(clk), .rst(rst), .rd_en(arr_rd_en), .rd_addr(rd_index),
            .we(fill_way), .wr_addr(req_q.index), .din(tagv_wdata), .dout(tagv_rdata[w])
        );

        way_ram #(.payload_t(logic)) u_dirty (
            .clk(clk), .rst(rst), .rd_en(arr_rd_en), .rd_addr(rd_index),
            .we(fill_way || (store_hit && hit[w])), .wr_addr(req_q.index),
            .din(dirty_wdata), .dout(dirty_rdata[w])
        );

        line_ram u_data (
            .clk(clk), .rd_en(arr_rd_en), .rd_addr(rd_index), .word_we(word_we),
            .wr_addr(line_wr_index), .din(line_wdata), .dout(line_rdata[w])
        );
    end

    assign lru_touch = rsp_valid || refill_we;
    assign lru_way   = refill_we ? victim : hit_way;

    lru_table u_lru (
        .clk(clk), .rst(rst), .index(req_q.index),
        .touch(lru_touch), .touch_way(lru_way), .victim(victim)
    );

    miss_fsm u_fsm (
        .clk(clk), .rst(rst), .lookup_miss(lookup_miss),
        .victim_dirty(dirty_rdata[victim]), .mem_rsp(mem_rsp), .state(state)
    );

    always_comb begin
        mem_req.rd_req  = state == MISS_CLEAN;
        mem_req.rd_addr = {req_q.tag, req_q.index, offset_t'(0)};
        mem_req.wr_req  = state == MISS_DIRTY;
        mem_req.wr_addr = {tagv_rdata[victim].tag, req_q.index, offset_t'(0)};   // victim line
        mem_req.wr_line = line_rdata[victim];
    end

endmodule

/* testbench/tb_clock.sv */
// clock and reset generator for the testbench
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* testbench/mem_fill.svh */
// initial memory word pattern as a hash of the whole byte address and a salt

function automatic logic [31:0] fill_word(input logic [31:0] salt, input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h9e37_79b1;
    h = h ^ {h[15:0], h[31:16]} ^ salt;   // every address bit reaches the upper half
    return h;
endfunction

/* testbench/mem_model.sv */
// backing memory on the line bus with fixed rdy and return delays
`timescale 1ns/10ps

module mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           salt,
    input  mem_bus_pkg::mem_req_t mem_req,
    output mem_bus_pkg::mem_rsp_t mem_rsp
);

    import mem_bus_pkg::*;

    `include "mem_fill.svh"

    line_t      lines [1024];   // 16 KB window, line number from addr[13:4]
    logic       rd_wait;        // rdy sent, return pending
    logic       wr_wait;
    logic [2:0] rd_cnt;
    logic [2:0] wr_cnt;
    logic [9:0] rd_idx;
    logic [9:0] wr_idx;
    line_t      wr_data;

    always_ff @(posedge clk) begin
        mem_rsp.rd_rdy    <= 1'b0;
        mem_rsp.ret_valid <= 1'b0;
        mem_rsp.wr_rdy    <= 1'b0;
        mem_rsp.wr_done   <= 1'b0;
        if (rst) begin
            rd_wait          <= 1'b0;
            wr_wait          <= 1'b0;
            rd_cnt           <= '0;
            wr_cnt           <= '0;
            mem_rsp.ret_line <= '0;
            for (int i = 0; i < 1024; i++) begin
                for (int w = 0; w < 4; w++) begin
                    lines[i][32*w +: 32] <= fill_word(salt, 32'(i * 16 + w * 4));
                end
            end
        end else begin
            // read: rdy two cycles after rd_req, line three cycles later
            if (!rd_wait) begin
                if (mem_req.rd_req && !mem_rsp.rd_rdy) begin
                    if (rd_cnt == 3'd1) begin
                        mem_rsp.rd_rdy <= 1'b1;
                        rd_wait        <= 1'b1;
                        rd_cnt         <= '0;
                        rd_idx         <= mem_req.rd_addr[13:4];
                    end else begin
                        rd_cnt <= rd_cnt + 3'd1;
                    end
                end
            end else if (rd_cnt == 3'd2) begin
                mem_rsp.ret_valid <= 1'b1;
                mem_rsp.ret_line  <= lines[rd_idx];
                rd_wait           <= 1'b0;
                rd_cnt            <= '0;
            end else begin
                rd_cnt <= rd_cnt + 3'd1;
            end
            // write takes the line at rdy and commits it at done
            if (!wr_wait) begin
                if (mem_req.wr_req && !mem_rsp.wr_rdy) begin
                    if (wr_cnt == 3'd1) begin
                        mem_rsp.wr_rdy <= 1'b1;
                        wr_wait        <= 1'b1;
                        wr_cnt         <= '0;
                        wr_idx         <= mem_req.wr_addr[13:4];
                        wr_data        <= mem_req.wr_line;
                    end else begin
                        wr_cnt <= wr_cnt + 3'd1;
                    end
                end
            end else if (wr_cnt == 3'd2) begin
                mem_rsp.wr_done <= 1'b1;
                lines[wr_idx]   <= wr_data;
                wr_wait         <= 1'b0;
                wr_cnt          <= '0;
            end else begin
                wr_cnt <= wr_cnt + 3'd1;
            end
        end
    end

endmodule

/* testbench/dcache_tb.sv */
// testbench top with directed tests, reference model, compare tasks, timeout and summary
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_tb;

    import dcache_pkg::*;
    import mem_bus_pkg::*;

    `include "mem_fill.svh"

    // about 20 accesses of at most 20 cycles each with a tenfold margin
    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        rst;
    logic        req_valid;
    cpu_req_t    req;
    logic        busy;
    logic        rsp_valid;
    logic [31:0] rdata;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic [31:0] salt;

    logic [31:0] ref_mem [4096];   // architectural word values
    tag_t        m_tag   [`DC_SETS][`DC_WAYS];
    logic        m_valid [`DC_SETS][`DC_WAYS];
    logic        m_dirty [`DC_SETS][`DC_WAYS];
    way_t        m_lru   [`DC_SETS];

    int          cycle_count = 0;
    int          rd_count = 0;
    int          wr_count = 0;
    logic [31:0] rd_addr_seen;
    logic [31:0] wr_addr_seen;
    line_t       wr_line_seen;
    int          errors = 0;
    int          test_errors;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name;

    tb_clock u_clock (.clk(clk), .rst(rst));

    mem_model u_mem (.clk(clk), .rst(rst), .salt(salt), .mem_req(mem_req), .mem_rsp(mem_rsp));

    dcache_top dut (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req), .busy(busy),
        .rsp_valid(rsp_valid), .rdata(rdata), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // bus monitor counts one per rdy handshake
    always @(posedge clk) begin
        if (mem_req.rd_req && mem_rsp.rd_rdy) begin
            rd_count     <= rd_count + 1;
            rd_addr_seen <= mem_req.rd_addr;
        end
        if (mem_req.wr_req && mem_rsp.wr_rdy) begin
            wr_count     <= wr_count + 1;
            wr_addr_seen <= mem_req.wr_addr;
            wr_line_seen <= mem_req.wr_line;
        end
    end

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_line(input string what, input line_t exp, input line_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    function automatic logic [31:0] merge_strb(input logic [31:0] old_w, input logic [31:0] new_w,
                                               input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};   // one lane per strobe
        return (new_w & mask) | (old_w & ~mask);
    endfunction

    function automatic line_t ref_line(input logic [31:0] line_addr);
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[32*w +: 32] = ref_mem[{line_addr[13:4], 2'(w)}];
        end
        return l;
    endfunction

    // presence model with hit or LRU victim and writeback when dirty
    task automatic model_access(input logic [31:0] addr, output logic miss, output logic wb,
                                output logic [31:0] wb_addr, output way_t way);
        index_t set_i;
        tag_t   tag;
        set_i   = addr[9:4];
        tag     = addr[31:10];
        miss    = 1'b1;
        wb      = 1'b0;
        wb_addr = '0;
        way     = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (m_valid[set_i][w] && m_tag[set_i][w] == tag) begin
                miss = 1'b0;
                way  = way_t'(w);
            end
        end
        if (miss) begin
            way     = m_lru[set_i];
            wb      = m_valid[set_i][way] && m_dirty[set_i][way];
            wb_addr = {m_tag[set_i][way], set_i, 4'b0};
            m_valid[set_i][way] = 1'b1;
            m_tag[set_i][way]   = tag;
            m_dirty[set_i][way] = 1'b0;
        end
        m_lru[set_i] = ~way;
    endtask

    task automatic drive_req(input logic is_store, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb);
        req_valid  = 1'b1;
        req.op     = is_store;
        req.tag    = addr[31:10];
        req.index  = addr[9:4];
        req.offset = addr[3:0];
        req.wstrb  = wstrb;
        req.wdata  = wdata;
    endtask

    task automatic issue(input logic is_store, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, output logic [31:0] data);
        @(negedge clk);
        while (busy) @(negedge clk);
        drive_req(is_store, addr, wdata, wstrb);
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) @(negedge clk);
        data = rdata;
    endtask

    // one access with bus and data checks against the reference
    task automatic cpu_op(input logic is_store, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] wstrb);
        logic        exp_miss;
        logic        exp_wb;
        logic [31:0] exp_wb_addr;
        logic [31:0] got;
        way_t        way;
        line_t       exp_wb_line;
        int          rd_before;
        int          wr_before;
        model_access(addr, exp_miss, exp_wb, exp_wb_addr, way);
        exp_wb_line = ref_line(exp_wb_addr);
        rd_before   = rd_count;
        wr_before   = wr_count;
        issue(is_store, addr, wdata, wstrb, got);
        check_flag("rd_req seen", exp_miss, rd_count != rd_before);
        if (exp_miss) check_word("rd_addr", {addr[31:4], 4'b0}, rd_addr_seen);
        check_flag("wr_req seen", exp_wb, wr_count != wr_before);
        if (exp_wb) begin
            check_word("wr_addr", exp_wb_addr, wr_addr_seen);
            check_line("wr_line", exp_wb_line, wr_line_seen);
        end
        if (is_store) begin
            check_word("store rdata", 32'h0, got);
            ref_mem[addr[13:2]] = merge_strb(ref_mem[addr[13:2]], wdata, wstrb);
            m_dirty[addr[9:4]][way] = 1'b1;
        end else begin
            check_word("load rdata", ref_mem[addr[13:2]], got);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test;
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("%s: %s (%0d errors)", test_name, test_errors == 0 ? "ok" : "FAILED",
                 test_errors);
    endtask

    task automatic test_cold_load;
        begin_test("cold_load");
        cpu_op(1'b0, 32'h0000_0104, '0, '0);
        end_test();
    endtask

    task automatic test_same_line;
        begin_test("same_line");
        cpu_op(1'b0, 32'h0000_0108, '0, '0);
        end_test();
    endtask

    // store hit, then a load of that word on the very next edge
    task automatic test_store_bypass;
        logic        miss;
        logic        wb;
        logic [31:0] wb_addr;
        logic [31:0] exp;
        way_t        way;
        int          rd_before;
        begin_test("store_bypass");
        model_access(32'h0000_010c, miss, wb, wb_addr, way);
        m_dirty[6'h10][way] = 1'b1;
        exp = merge_strb(ref_mem[12'h043], 32'ha5a5_5a5a, 4'b0101);
        ref_mem[12'h043] = exp;
        model_access(32'h0000_010c, miss, wb, wb_addr, way);
        rd_before = rd_count;
        @(negedge clk);
        while (busy) @(negedge clk);
        drive_req(1'b1, 32'h0000_010c, 32'ha5a5_5a5a, 4'b0101);
        @(negedge clk);
        check_flag("store rsp_valid", 1'b1, rsp_valid);
        check_word("store rdata", 32'h0, rdata);
        drive_req(1'b0, 32'h0000_010c, '0, '0);
        @(negedge clk);
        req_valid = 1'b0;
        check_flag("bypass rsp_valid", 1'b1, rsp_valid);
        check_word("bypass rdata", exp, rdata);
        check_flag("rd_req seen", 1'b0, rd_count != rd_before);
        repeat (2) @(negedge clk);
        cpu_op(1'b0, 32'h0000_010c, '0, '0);   // now from the data array
        end_test();
    endtask

    // set 4 holds lines A and B, then A is touched and C evicts B
    task automatic test_lru_evict;
        begin_test("lru_evict");
        cpu_op(1'b0, 32'h0000_0040, '0, '0);
        cpu_op(1'b0, 32'h0000_0440, '0, '0);
        cpu_op(1'b0, 32'h0000_0044, '0, '0);
        cpu_op(1'b0, 32'h0000_0840, '0, '0);
        cpu_op(1'b0, 32'h0000_0048, '0, '0);   // A stays resident
        cpu_op(1'b0, 32'h0000_0444, '0, '0);   // B refetched
        end_test();
    endtask

    // set 8 sees dirty D evicted by F and then clean E evicted by D
    task automatic test_writeback;
        begin_test("writeback");
        cpu_op(1'b0, 32'h0000_0080, '0, '0);
        cpu_op(1'b1, 32'h0000_0084, 32'h1234_5678, 4'b1111);
        cpu_op(1'b1, 32'h0000_0088, 32'hdead_beef, 4'b1000);
        cpu_op(1'b0, 32'h0000_0480, '0, '0);
        cpu_op(1'b0, 32'h0000_0880, '0, '0);
        cpu_op(1'b0, 32'h0000_0084, '0, '0);
        cpu_op(1'b0, 32'h0000_0088, '0, '0);
        end_test();
    endtask

    initial begin
        req_valid = 1'b0;
        req       = '0;
        void'($urandom(32'heb3c_868a));
        salt = $urandom;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = fill_word(salt, 32'(i * 4));
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            m_lru[s] = '0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        @(negedge clk);
        while (rst) @(negedge clk);
        begin_test("reset_state");
        check_flag("busy", 1'b0, busy);
        check_flag("rsp_valid", 1'b0, rsp_valid);
        check_flag("rd_req", 1'b0, mem_req.rd_req);
        check_flag("wr_req", 1'b0, mem_req.wr_req);
        end_test();
        test_cold_load();
        test_same_line();
        test_store_bypass();
        test_lru_evict();
        test_writeback();
        $display("tests run %0d, tests failed %0d, check errors %0d, cycles %0d",
                 tests_run, tests_failed, errors, cycle_count);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
+incdir+testbench
design/dcache_pkg.sv
design/mem_bus_pkg.sv
design/way_ram.sv
design/line_ram.sv
design/lru_table.sv
design/miss_fsm.sv
design/dcache_top.sv
testbench/tb_clock.sv
testbench/mem_model.sv
testbench/dcache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
